/* common/arkanoid_input_defs.svh */
// Arkanoid player-input constants
// Scan codes, joystick bit map, divider counts and widths shared by the input blocks
`ifndef ARKANOID_INPUT_DEFS_SVH
`define ARKANOID_INPUT_DEFS_SVH

`define ARK_POS_W       12      // Signed spinner position accumulator
`define ARK_CE6_DIV     8       // 48 MHz / 8 = 6 MHz tick
`define ARK_STEP_DIV    1500    // 6 MHz / 1500 = 4 kHz quadrature step
`define ARK_POLL_TICKS  48000   // Roughly 8 ms, a 125 Hz mouse poll
`define ARK_DPAD_SLOW   4
`define ARK_DPAD_FAST   9
`define ARK_CE12_DIV    4       // Encoder sampling at 12 MHz
`define ARK_DIP_INDEX   8'd254  // Loader index of the DIP bank

// PS/2 set 2 make codes
`define ARK_KEY_START1  8'h16   // 1
`define ARK_KEY_START2  8'h1E   // 2
`define ARK_KEY_COIN1   8'h2E   // 5
`define ARK_KEY_COIN2   8'h36   // 6
`define ARK_KEY_SERVICE 8'h46   // 9
`define ARK_KEY_PAUSE   8'h4D   // P
`define ARK_KEY_FAST    8'h11   // Alt
`define ARK_KEY_LEFT    8'h6B
`define ARK_KEY_RIGHT   8'h74
`define ARK_KEY_FIRE    8'h29   // Space

// Joystick word bit positions
`define ARK_JOY_RIGHT   0
`define ARK_JOY_LEFT    1
`define ARK_JOY_FIRE    4
`define ARK_JOY_FAST    5
`define ARK_JOY_START1  6
`define ARK_JOY_COIN1   7
`define ARK_JOY_START2  8
`define ARK_JOY_PAUSE   9

`endif

/* common/arkanoid_input_pkg.sv */
// Arkanoid input package
// Quadrature phase stepping shared by the emulated spinner and the encoder path
package arkanoid_input_pkg;

	//////////////////////////////
	// Forward runs 00 01 11 10, reverse runs it backwards
	function automatic logic [1:0] quad_step(input logic [1:0] phase, input logic dir);
		logic [1:0] next;
		case (phase)
			2'b00:   next = dir ? 2'b01 : 2'b10;
			2'b01:   next = dir ? 2'b11 : 2'b00;
			2'b11:   next = dir ? 2'b10 : 2'b01;
			default: next = dir ? 2'b00 : 2'b11;  // Phase 10
		endcase
		return next;
	endfunction

endpackage

/* common/arcade_buttons_if.sv */
// Arcade button bundle
// Held keyboard levels, active high, passed from the PS/2 decoder to the merge logic
`timescale 1ns/1ns

interface arcade_buttons_if;

	logic left;     // Paddle left
	logic right;    // Paddle right
	logic fast;     // D-pad speed modifier
	logic fire;
	logic start1;
	logic start2;
	logic coin1;
	logic coin2;
	logic service;
	logic pause;    // Decoded only, no cabinet pin

	// Decoder side
	modport kbd (
		output left, right, fast, fire, start1, start2, coin1, coin2, service, pause
	);

	// Merge side
	modport merge (
		input left, right, fast, fire, start1, start2, coin1, coin2, service, pause
	);

endinterface

/* hw/controls/kbd_decoder.sv */
// PS/2 keyboard decoder
// Watches the event toggle of the PS/2 key word and holds one level per
// arcade button, set on make and cleared on break. Unknown codes are ignored
`timescale 1ns/1ns
`include "arkanoid_input_defs.svh"

module kbd_decoder (
	input  logic        CLK_48M,
	input  logic        rst,
	input  logic [10:0] ps2_key,   // [10] toggle, [9] pressed, [7:0] code
	arcade_buttons_if.kbd btn
);

	logic       old_toggle;
	logic       pressed;
	logic [7:0] code;

	assign pressed = ps2_key[9];
	assign code    = ps2_key[7:0];

	always_ff @(posedge CLK_48M) begin
		if (rst) begin
			old_toggle  <= 1'b0;
			btn.left    <= 1'b0;
			btn.right   <= 1'b0;
			btn.fast    <= 1'b0;
			btn.fire    <= 1'b0;
			btn.start1  <= 1'b0;
			btn.start2  <= 1'b0;
			btn.coin1   <= 1'b0;
			btn.coin2   <= 1'b0;
			btn.service <= 1'b0;
			btn.pause   <= 1'b0;
		end else begin
			old_toggle <= ps2_key[10];
			if (old_toggle != ps2_key[10]) begin  // New key event
				case (code)
					`ARK_KEY_START1:  btn.start1  <= pressed;
					`ARK_KEY_START2:  btn.start2  <= pressed;
					`ARK_KEY_COIN1:   btn.coin1   <= pressed;
					`ARK_KEY_COIN2:   btn.coin2   <= pressed;
					`ARK_KEY_SERVICE: btn.service <= pressed;
					`ARK_KEY_PAUSE:   btn.pause   <= pressed;
					`ARK_KEY_FAST:    btn.fast    <= pressed;
					`ARK_KEY_LEFT:    btn.left    <= pressed;
					`ARK_KEY_RIGHT:   btn.right   <= pressed;
					`ARK_KEY_FIRE:    btn.fire    <= pressed;
					default: ;  // Not a game key
				endcase
			end
		end
	end

	// Pause only ever rises after a pause make code
	a_pause_src: assert property (@(posedge CLK_48M) disable iff (rst)
		$rose(btn.pause) |-> $past(code) == `ARK_KEY_PAUSE)
		else $error("pause set by scan code %h", $past(code));

endmodule

/* hw/controls/cabinet_inputs.sv */
// Cabinet input merge
// ORs keyboard, joystick, mouse buttons and user-port fire into the
// active-low cabinet inputs, and keeps the DIP switch byte from the loader
`timescale 1ns/1ns
`include "arkanoid_input_defs.svh"

module cabinet_inputs (
	input  logic        CLK_48M,
	input  logic        rst,
	arcade_buttons_if.merge btn,
	input  logic [31:0] joystick,
	input  logic [1:0]  mouse_buttons,
	input  logic        user_fire_n,    // User-port fire, active low
	input  logic        use_io,         // Real encoder in use
	input  logic        ioctl_wr,
	input  logic [7:0]  ioctl_index,
	input  logic [24:0] ioctl_addr,
	input  logic [7:0]  ioctl_dout,
	output logic        left,           // Merged levels to the spinner
	output logic        right,
	output logic        fast,
	output logic        coin1,          // Cabinet side, active low
	output logic        coin2,
	output logic        btn_shot,
	output logic        btn_service,
	output logic        btn_1p_start,
	output logic        btn_2p_start,
	output logic [7:0]  dip_sw
);

	logic       fire;
	logic [7:0] dip_byte;  // Byte 0 of the DIP bank, as written

	//////////////////////////////
	// Merge, all combinational

	assign left  = btn.left  | joystick[`ARK_JOY_LEFT];
	assign right = btn.right | joystick[`ARK_JOY_RIGHT];
	assign fast  = btn.fast  | joystick[`ARK_JOY_FAST];

	// User-port fire only counts with the real spinner attached
	assign fire = btn.fire | joystick[`ARK_JOY_FIRE] | (|mouse_buttons) | (use_io & ~user_fire_n);

	assign coin1        = ~(btn.coin1 | joystick[`ARK_JOY_COIN1]);
	assign coin2        = ~btn.coin2;          // Keyboard only
	assign btn_shot     = ~fire;
	assign btn_service  = ~btn.service;
	assign btn_1p_start = ~(btn.start1 | joystick[`ARK_JOY_START1]);
	assign btn_2p_start = ~(btn.start2 | joystick[`ARK_JOY_START2]);

	//////////////////////////////
	// DIP capture

	always_ff @(posedge CLK_48M) begin
		if (rst)
			dip_byte <= 8'h00;
		else if (ioctl_wr && ioctl_index == `ARK_DIP_INDEX && ioctl_addr == 25'd0)
			dip_byte <= ioctl_dout;
	end

	assign dip_sw = ~dip_byte;  // Switches are active low on the board

endmodule

/* hw/spinner/encoder_downsampler.sv */
// Encoder pulse halving
// Samples the user-port quadrature pins at 12 MHz and steps a raw phase once
// per edge of pin A, so a 600 pulse encoder reads as the original 300
`timescale 1ns/1ns
`include "arkanoid_input_defs.svh"

module encoder_downsampler (
	input  logic       CLK_48M,
	input  logic       rst,
	input  logic [1:0] user_pins,   // [0] A, [1] B
	output logic [1:0] raw_phase
);

	import arkanoid_input_pkg::*;

	localparam int CE_W = $clog2(`ARK_CE12_DIV);

	logic [CE_W-1:0] ce_cnt;    // 12 MHz sample enable
	logic            pin_a_q;   // Last sampled A
	logic            pin_a;
	logic            pin_b;

	assign pin_a = user_pins[0];
	assign pin_b = user_pins[1];

	always_ff @(posedge CLK_48M) begin
		if (rst) begin
			ce_cnt    <= '0;
			pin_a_q   <= 1'b0;
			raw_phase <= 2'b11;
		end else begin
			ce_cnt <= (ce_cnt == CE_W'(`ARK_CE12_DIV - 1)) ? '0 : ce_cnt + 1'b1;
			if (ce_cnt == '0) begin
				pin_a_q <= pin_a;
				// B alone is ignored, A edges set the pace
				if (pin_a_q != pin_a)
					raw_phase <= quad_step(raw_phase, pin_a ^ pin_b);
			end
		end
	end

	// At most one bit of the phase moves per clock
	a_raw_gray: assert property (@(posedge CLK_48M) disable iff (rst)
		$countones(raw_phase ^ $past(raw_phase)) <= 1)
		else $error("raw phase jumped from %b to %b", $past(raw_phase), raw_phase);

endmodule

/* hw/spinner/spinner_emulator.sv */
// Spinner emulation
// Mouse X motion and held d-pad directions feed a signed position that is
// paid out as quadrature steps at 4 kHz. Pin activity on the user port
// switches the output over to the real encoder phase
`timescale 1ns/1ns
`include "arkanoid_input_defs.svh"

module spinner_emulator (
	input  logic        CLK_48M,
	input  logic        rst,
	input  logic [24:0] ps2_mouse,   // [24] toggle, [15:8] dx, [4] dx sign
	input  logic        left,
	input  logic        right,
	input  logic        fast,
	input  logic [1:0]  user_pins,   // Encoder A/B pins
	input  logic        io_enable,   // Real encoder allowed
	input  logic [1:0]  raw_phase,
	output logic        use_io,
	output logic [1:0]  spinner
);

	import arkanoid_input_pkg::*;

	localparam int POS_W  = `ARK_POS_W;
	localparam int CE_W   = $clog2(`ARK_CE6_DIV);
	localparam int STEP_W = $clog2(`ARK_STEP_DIV);
	localparam int POLL_W = $clog2(`ARK_POLL_TICKS + 1);

	localparam logic signed [POS_W-1:0] DPAD_SLOW = POS_W'(`ARK_DPAD_SLOW);
	localparam logic signed [POS_W-1:0] DPAD_FAST = POS_W'(`ARK_DPAD_FAST);

	logic [CE_W-1:0]          ce_cnt;      // 6 MHz tick divider
	logic [STEP_W-1:0]        step_cnt;    // 4 kHz step divider
	logic [POLL_W-1:0]        poll_cnt;    // D-pad poll timer
	logic signed [POS_W-1:0]  position;    // Steps still owed, sign is direction
	logic [1:0]               emu_phase;
	logic                     mouse_tog_q;
	logic [1:0]               pins_q;

	logic                     tick;
	logic                     step_now;
	logic                     mouse_evt;
	logic signed [POS_W-1:0]  pos_stepped;
	logic signed [POS_W-1:0]  mouse_dx;
	logic signed [POS_W-1:0]  dpad_load;

	assign tick      = (ce_cnt == '0);
	assign step_now  = (step_cnt == '0) && (position != '0);
	assign mouse_evt = (mouse_tog_q != ps2_mouse[24]);
	assign mouse_dx  = {{(POS_W-8){ps2_mouse[4]}}, ps2_mouse[15:8]};
	assign dpad_load = fast ? DPAD_FAST : DPAD_SLOW;

	// One unit toward zero per step taken
	assign pos_stepped = !step_now ? position :
	                     position[POS_W-1] ? position + 1'b1 : position - 1'b1;

	//////////////////////////////
	// Position and phase

	always_ff @(posedge CLK_48M) begin
		if (rst) begin
			ce_cnt      <= '0;
			step_cnt    <= '0;
			poll_cnt    <= '0;
			position    <= '0;
			emu_phase   <= 2'b11;
			mouse_tog_q <= 1'b0;
			pins_q      <= 2'b00;
			use_io      <= 1'b0;
		end else begin
			ce_cnt <= (ce_cnt == CE_W'(`ARK_CE6_DIV - 1)) ? '0 : ce_cnt + 1'b1;
			pins_q <= user_pins;

			if (tick) begin
				step_cnt    <= (step_cnt == STEP_W'(`ARK_STEP_DIV - 1)) ? '0 : step_cnt + 1'b1;
				mouse_tog_q <= ps2_mouse[24];

				if (step_now)  // Positive position steps forward
					emu_phase <= quad_step(emu_phase, ~position[POS_W-1]);
				position <= pos_stepped;

				if (mouse_evt) begin
					use_io <= 1'b0;
					if (!(^position[POS_W-1:POS_W-2]))  // Overflow guard
						position <= pos_stepped + mouse_dx;
				end

				// D-pad reloads the position once per poll while held
				if (left | right) begin
					use_io <= 1'b0;
					if (poll_cnt == POLL_W'(`ARK_POLL_TICKS)) begin
						position <= right ? dpad_load : -dpad_load;
						poll_cnt <= '0;
					end else begin
						poll_cnt <= poll_cnt + 1'b1;
					end
				end else begin
					poll_cnt <= '0;
				end
			end

			if (pins_q != user_pins)
				use_io <= 1'b1;   // Real encoder is turning
			if (!io_enable)
				use_io <= 1'b0;
		end
	end

	assign spinner = use_io ? raw_phase : emu_phase;

	// Emulated phase stays on the Gray sequence
	a_emu_gray: assert property (@(posedge CLK_48M) disable iff (rst)
		$countones(emu_phase ^ $past(emu_phase)) <= 1)
		else $error("emulated phase jumped from %b to %b", $past(emu_phase), emu_phase);

endmodule

/* hw/arkanoid_inputs.sv */
// Arkanoid player-input front end
// Keyboard decode, cabinet merge, DIP capture, spinner emulation and real
// encoder halving, wired to the game's cabinet inputs
`timescale 1ns/1ns

module arkanoid_inputs (
	input  logic        CLK_48M,
	input  logic        rst,
	input  logic [10:0] ps2_key,
	input  logic [24:0] ps2_mouse,
	input  logic [31:0] joystick,
	input  logic [1:0]  user_pins,     // Encoder A/B
	input  logic        user_fire_n,
	input  logic        io_enable,
	input  logic        ioctl_wr,
	input  logic [7:0]  ioctl_index,
	input  logic [24:0] ioctl_addr,
	input  logic [7:0]  ioctl_dout,
	output logic [1:0]  spinner,
	output logic        coin1,
	output logic        coin2,
	output logic        btn_shot,
	output logic        btn_service,
	output logic        btn_1p_start,
	output logic        btn_2p_start,
	output logic [7:0]  dip_sw
);

	logic       m_left;    // Merged d-pad levels
	logic       m_right;
	logic       m_fast;
	logic       use_io;
	logic [1:0] raw_phase;

	arcade_buttons_if kbd_btn ();

	kbd_decoder u_kbd_decoder (.CLK_48M, .rst, .ps2_key, .btn(kbd_btn));

	cabinet_inputs u_cabinet_inputs (
		.CLK_48M, .rst, .btn(kbd_btn), .joystick,
		.mouse_buttons(ps2_mouse[1:0]), .user_fire_n, .use_io,
		.ioctl_wr, .ioctl_index, .ioctl_addr, .ioctl_dout,
		.left(m_left), .right(m_right), .fast(m_fast),
		.coin1, .coin2, .btn_shot, .btn_service, .btn_1p_start, .btn_2p_start, .dip_sw
	);

	encoder_downsampler u_encoder_downsampler (.CLK_48M, .rst, .user_pins, .raw_phase);

	spinner_emulator u_spinner_emulator (
		.CLK_48M, .rst, .ps2_mouse, .left(m_left), .right(m_right), .fast(m_fast),
		.user_pins, .io_enable, .raw_phase, .use_io, .spinner
	);

endmodule

/* verification/tb_arkanoid_inputs.sv */
// Arkanoid input front end testbench
// Directed tests for reset state, DIP capture, keyboard and joystick merge,
// mouse and d-pad spinner emulation and the real encoder path
`timescale 1ns/1ns
`include "arkanoid_input_defs.svh"

module tb_arkanoid_inputs;

	import arkanoid_input_pkg::*;

	localparam int TICK_NS     = 4 * `ARK_CE6_DIV;                 // One 6 MHz tick
	localparam int STEP_NS     = TICK_NS * `ARK_STEP_DIV;          // One quadrature step
	localparam int POLL_NS     = TICK_NS * (`ARK_POLL_TICKS + 1);  // One d-pad poll
	localparam int WATCHDOG_NS = 3 * POLL_NS + 48 * STEP_NS;       // Three polls, steps, margin
	localparam int QUIET_CLKS  = 2 * `ARK_STEP_DIV * `ARK_CE6_DIV; // Motion over after two steps

	logic        CLK_48M = 1'b0;
	logic        rst;
	logic [10:0] ps2_key;
	logic [24:0] ps2_mouse;
	logic [31:0] joystick;
	logic [1:0]  user_pins;    // {B, A}
	logic        user_fire_n;
	logic        io_enable;
	logic        ioctl_wr;
	logic [7:0]  ioctl_index;
	logic [24:0] ioctl_addr;
	logic [7:0]  ioctl_dout;
	logic [1:0]  spinner;
	logic        coin1, coin2, btn_shot, btn_service, btn_1p_start, btn_2p_start;
	logic [7:0]  dip_sw;

	integer      seed = 58;
	logic [1:0]  emu_model;    // Predicted emulated phase
	logic [1:0]  raw_model;    // Predicted encoder phase

	always #2 CLK_48M = ~CLK_48M;  // 4 ns period

	arkanoid_inputs u_arkanoid_inputs (.*);

	//////////////////////////////
	// Checks

	task automatic stop_with_failure();
		$display("*** TEST FAILED ***");
		$fatal(1, "run stopped at the first failure");
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("ERR %s: expected %b, got %b", name, exp, act);
			stop_with_failure();
		end
	endtask

	task automatic check_phase(input string name, input logic [1:0] exp, input logic [1:0] act);
		if (act !== exp) begin
			$display("ERR %s: expected %b, got %b", name, exp, act);
			stop_with_failure();
		end
	endtask

	task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp) begin
			$display("ERR %s: expected %h, got %h", name, exp, act);
			stop_with_failure();
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (act != exp) begin
			$display("ERR %s: expected %0d steps, got %0d", name, exp, act);
			stop_with_failure();
		end
	endtask

	//////////////////////////////
	// Stimulus helpers

	task automatic drive_slot();
		@(posedge CLK_48M);
		#1;  // Inputs change just after the edge
	endtask

	task automatic send_key(input logic [7:0] code, input logic pressed);
		drive_slot();
		ps2_key = {~ps2_key[10], pressed, 1'b0, code};  // Flip toggle for a new event
	endtask

	task automatic send_mouse(input int dx);
		drive_slot();
		ps2_mouse[24]   = ~ps2_mouse[24];
		ps2_mouse[15:8] = dx[7:0];
		ps2_mouse[4]    = (dx < 0);  // X sign
	endtask

	task automatic write_ioctl(input logic [7:0] index, input logic [24:0] addr,
	                           input logic [7:0] data);
		drive_slot();
		ioctl_wr    = 1'b1;
		ioctl_index = index;
		ioctl_addr  = addr;
		ioctl_dout  = data;
		drive_slot();
		ioctl_wr = 1'b0;
		@(negedge CLK_48M);
	endtask

	// Cabinet outputs in index order 1P start, 2P start, coin1, coin2, service, shot
	function automatic logic cab_out(input int idx);
		case (idx)
			0:       return btn_1p_start;
			1:       return btn_2p_start;
			2:       return coin1;
			3:       return coin2;
			4:       return btn_service;
			default: return btn_shot;
		endcase
	endfunction

	// Follow the phase until it settles, predicting each step
	task automatic follow_steps(input string name, input logic dir, input int n);
		int steps;
		int quiet;
		steps = 0;
		quiet = 0;
		while (quiet < QUIET_CLKS) begin
			@(negedge CLK_48M);
			if (spinner !== emu_model) begin
				emu_model = quad_step(emu_model, dir);
				check_phase(name, emu_model, spinner);
				steps++;
				quiet = 0;
			end else begin
				quiet++;
			end
		end
		check_count(name, n, steps);
	endtask

	task automatic wait_first_step(input string name, input logic dir);
		while (spinner === emu_model)
			@(negedge CLK_48M);
		emu_model = quad_step(emu_model, dir);
		check_phase(name, emu_model, spinner);
	endtask

	//////////////////////////////
	// Tests

	task automatic test_reset();
		for (int i = 0; i < 6; i++)
			check_bit($sformatf("reset output %0d", i), 1'b1, cab_out(i));
		check_phase("reset spinner", 2'b11, spinner);
		check_byte("reset dip_sw", 8'hff, dip_sw);
	endtask

	task automatic test_dip();
		logic [7:0] data;
		data = 8'($random(seed));
		write_ioctl(`ARK_DIP_INDEX, 25'd0, data);
		check_byte("dip write", ~data, dip_sw);
		write_ioctl(`ARK_DIP_INDEX, 25'd1, ~data);  // Other byte of the bank
		check_byte("dip address 1", ~data, dip_sw);
		write_ioctl(8'd0, 25'd0, ~data);
		check_byte("dip index 0", ~data, dip_sw);
	endtask

	task automatic test_keys();
		logic [7:0] codes [6];
		int         joy_bit [4];
		int         joy_out [4];
		codes   = '{`ARK_KEY_START1, `ARK_KEY_START2, `ARK_KEY_COIN1,
		            `ARK_KEY_COIN2, `ARK_KEY_SERVICE, `ARK_KEY_FIRE};
		joy_bit = '{`ARK_JOY_START1, `ARK_JOY_START2, `ARK_JOY_COIN1, `ARK_JOY_FIRE};
		joy_out = '{0, 1, 2, 5};
		for (int i = 0; i < 6; i++) begin
			send_key(codes[i], 1'b1);
			@(negedge CLK_48M);
			check_bit("key before latch", 1'b1, cab_out(i));
			@(negedge CLK_48M);
			check_bit("key press", 1'b0, cab_out(i));
			send_key(codes[i], 1'b0);
			repeat (2) @(negedge CLK_48M);
			check_bit("key release", 1'b1, cab_out(i));
		end
		for (int i = 0; i < 4; i++) begin
			drive_slot();
			joystick[joy_bit[i]] = 1'b1;
			@(negedge CLK_48M);
			check_bit("joystick press", 1'b0, cab_out(joy_out[i]));  // Combinational merge
			drive_slot();
			joystick = '0;
		end
		for (int b = 0; b < 2; b++) begin
			drive_slot();
			ps2_mouse[1:0] = 2'b01 << b;  // Left then right mouse button
			@(negedge CLK_48M);
			check_bit("mouse button", 1'b0, btn_shot);
		end
		drive_slot();
		ps2_mouse[1:0] = 2'b00;
		user_fire_n    = 1'b0;
		@(negedge CLK_48M);
		check_bit("user fire, no encoder", 1'b1, btn_shot);
		drive_slot();
		user_pins = 2'b10;  // B alone leaves the raw phase
		repeat (2) @(negedge CLK_48M);
		check_bit("user fire, encoder", 1'b0, btn_shot);
		drive_slot();
		user_fire_n = 1'b1;
	endtask

	task automatic test_mouse();
		int   mag;
		logic dir;
		mag = 1 + ($unsigned($random(seed)) % 3);
		dir = 1'($random(seed));
		send_mouse(dir ? mag : -mag);  // Also hands the output back to emulation
		follow_steps("mouse motion", dir, mag);
	endtask

	task automatic test_dpad(input string name, input logic [7:0] code, input logic dir,
	                         input logic fast_key, input int n);
		if (fast_key)
			send_key(`ARK_KEY_FAST, 1'b1);
		send_key(code, 1'b1);
		wait_first_step(name, dir);
		send_key(code, 1'b0);  // Released right after the first poll
		if (fast_key)
			send_key(`ARK_KEY_FAST, 1'b0);
		follow_steps(name, dir, n - 1);
	endtask

	task automatic test_encoder();
		logic [1:0] pins;
		pins = user_pins;
		// Gray run forward, then back until the encoder phase differs from the emulated one
		for (int i = 0; i < 12 || raw_model === emu_model; i++) begin
			pins = quad_step(pins, i < 8);
			drive_slot();
			if (pins[0] != user_pins[0])
				raw_model = quad_step(raw_model, pins[0] ^ pins[1]);
			user_pins = pins;
			repeat (2 * `ARK_CE12_DIV) @(negedge CLK_48M);
			check_phase("encoder", raw_model, spinner);
		end
		send_mouse(0);
		repeat (2 * `ARK_CE6_DIV) @(negedge CLK_48M);
		check_phase("back to emulated", emu_model, spinner);
	endtask

	//////////////////////////////
	// Run

	initial begin
		rst         = 1'b1;
		ps2_key     = '0;
		ps2_mouse   = '0;
		joystick    = '0;
		user_pins   = 2'b00;
		user_fire_n = 1'b1;
		io_enable   = 1'b1;
		ioctl_wr    = 1'b0;
		ioctl_index = '0;
		ioctl_addr  = '0;
		ioctl_dout  = '0;
		emu_model   = 2'b11;
		raw_model   = 2'b11;
		repeat (2) @(posedge CLK_48M);
		#1 rst = 1'b0;
		@(negedge CLK_48M);
		test_reset();
		test_dip();
		test_keys();
		test_mouse();
		test_dpad("dpad right", `ARK_KEY_RIGHT, 1'b1, 1'b0, `ARK_DPAD_SLOW);
		test_dpad("dpad right fast", `ARK_KEY_RIGHT, 1'b1, 1'b1, `ARK_DPAD_FAST);
		test_dpad("dpad left", `ARK_KEY_LEFT, 1'b0, 1'b0, `ARK_DPAD_SLOW);
		test_encoder();
		$display("*** TEST PASSED ***");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns with a test still running", WATCHDOG_NS);
		stop_with_failure();
	end

endmodule

/* arkanoid_inputs.f */
+incdir+common
common/arkanoid_input_pkg.sv
common/arcade_buttons_if.sv
hw/controls/kbd_decoder.sv
hw/controls/cabinet_inputs.sv
hw/spinner/encoder_downsampler.sv
hw/spinner/spinner_emulator.sv
hw/arkanoid_inputs.sv
verification/tb_arkanoid_inputs.sv

/* Makefile */
# Verilator flow for the Arkanoid input front end
TB  = tb_arkanoid_inputs
OBJ = obj_dir

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TB) \
		-f arkanoid_inputs.f --Mdir $(OBJ) -o V$(TB)
	@out=$$(./$(OBJ)/V$(TB)); echo "$$out"; echo "$$out" | grep -qF '*** TEST PASSED ***'

lint:
	verilator --lint-only -Wall --timing --top-module arkanoid_inputs -f arkanoid_inputs.f

clean:
	rm -rf $(OBJ)
